// ==== tcb_settings.svh ====
// bus and memory sizing macros for the TCB subsystem
// data width, byte lanes, offset, size code, addresses, depth, delay

`ifndef TCB_SETTINGS_SVH
`define TCB_SETTINGS_SVH

// data word and its byte lanes
`define TCB_DAT_W 32
`define TCB_BYT_N 4
// byte offset inside a word
`define TCB_OFF_W 2
// logarithmic size code, 0 byte, 1 half, 2 word
`define TCB_SIZ_W 2
// byte address and word address
`define TCB_ADR_W 12
`define TCB_WAD_W (`TCB_ADR_W - `TCB_OFF_W)
// memory depth in words
`define TCB_MEM_D 1024
// limit register, one bit wider so the full depth fits
`define TCB_LIM_W (`TCB_WAD_W + 1)
// response delay in cycles
`define TCB_DLY 1

`endif

// ==== tcb_pkg.sv ====
// shared types for the TCB subsystem
// data word union with word and byte views

`include "tcb_settings.svh"

package tcb_pkg;

  //////////////////////////////////////////////////
  // data word
  //////////////////////////////////////////////////

  // byte lane array
  typedef logic [`TCB_BYT_N-1:0][7:0] tcb_byt_t;

  // one bus word, decoded either whole or per lane
  typedef union packed {
    // whole word, used by memory and top ports
    logic [`TCB_DAT_W-1:0] wrd;
    // byte lanes, used by the size converter
    tcb_byt_t              byt;
  } tcb_data_t;

endpackage

// ==== tcb_cfg_regs.sv ====
// configuration registers for the TCB subsystem
// endianness bit and memory address limit, strobe write, mux readback

`timescale 1ns/1ps

`include "tcb_settings.svh"

module tcb_cfg_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  // configuration port
  input  logic                   cfg_wen,
  input  logic                   cfg_adr,
  input  tcb_pkg::tcb_data_t     cfg_wdt,
  output tcb_pkg::tcb_data_t     cfg_rdt,
  // control outputs
  output logic                   ndn,
  output logic [`TCB_LIM_W-1:0]  lim
);

  // register address map
  localparam logic CFG_NDN = 1'b0;
  localparam logic CFG_LIM = 1'b1;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  // little-endian and full depth out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ndn <= 1'b0;
      lim <= `TCB_LIM_W'(`TCB_MEM_D);
    end else if (cfg_wen) begin
      case (cfg_adr)
        CFG_NDN: ndn <= cfg_wdt.wrd[0];
        CFG_LIM: lim <= cfg_wdt.wrd[`TCB_LIM_W-1:0];
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////

  // unused bits read as zero
  always_comb begin
    cfg_rdt = '0;
    case (cfg_adr)
      CFG_NDN: cfg_rdt.wrd[0] = ndn;
      CFG_LIM: cfg_rdt.wrd[`TCB_LIM_W-1:0] = lim;
      default: ;
    endcase
  end

endmodule

// ==== tcb_logsize2byteena.sv ====
// logarithmic size to byte enable converter
// combinational request path, read steering from registered offset,
// size and endianness

`timescale 1ns/1ps

`include "tcb_settings.svh"

module tcb_logsize2byteena (
  input  logic                   clk,
  input  logic                   rst_n,
  // manager side, log size mode
  input  logic                   vld,
  input  logic                   wen,
  input  logic [`TCB_ADR_W-1:0]  adr,
  input  logic [`TCB_SIZ_W-1:0]  siz,
  input  tcb_pkg::tcb_data_t     wdt,
  input  logic                   ndn,
  output logic                   rdy,
  output tcb_pkg::tcb_data_t     rdt,
  output logic                   sts,
  // memory side, byte enable mode
  output logic                   mem_vld,
  output logic                   mem_wen,
  output logic [`TCB_WAD_W-1:0]  mem_adr,
  output logic [`TCB_BYT_N-1:0]  mem_ben,
  output tcb_pkg::tcb_data_t     mem_wdt,
  input  tcb_pkg::tcb_data_t     mem_rdt,
  input  logic                   mem_sts,
  input  logic                   mem_rdy
);

  // transfer strobe
  logic                  trn;
  // request offset and index of the last byte
  logic [`TCB_OFF_W-1:0] req_off;
  logic [`TCB_OFF_W-1:0] req_top;
  // unrotated enables, low bytes only
  logic [`TCB_BYT_N-1:0] siz_ben;
  // response side copies taken at the transfer
  logic [`TCB_OFF_W-1:0] rsp_off;
  logic [`TCB_SIZ_W-1:0] rsp_siz;
  logic                  rsp_ndn;
  logic [`TCB_OFF_W-1:0] rsp_top;

  //////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////

  // handshake and control go straight through
  assign mem_vld = vld;
  assign mem_wen = wen;
  assign rdy     = mem_rdy;
  assign trn     = vld & mem_rdy;

  // split byte address into word and offset
  assign mem_adr = adr[`TCB_ADR_W-1:`TCB_OFF_W];
  assign req_off = adr[`TCB_OFF_W-1:0];
  // 2**siz - 1, wraps to lane index width
  assign req_top = `TCB_OFF_W'((1 << siz) - 1);

  // low 2**siz bytes enabled
  always_comb begin
    for (int i = 0; i < `TCB_BYT_N; i++) begin
      siz_ben[i] = (i < (1 << siz));
    end
  end

  // rotate enables and data onto lanes, offset wraps mod bus width
  always_comb begin
    for (int i = 0; i < `TCB_BYT_N; i++) begin
      mem_ben[i] = siz_ben[`TCB_OFF_W'(i) - req_off];
      if (ndn) begin
        // big-endian, most significant byte at the lowest lane
        mem_wdt.byt[i] = wdt.byt[req_top - `TCB_OFF_W'(i) + req_off];
      end else begin
        mem_wdt.byt[i] = wdt.byt[`TCB_OFF_W'(i) - req_off];
      end
    end
  end

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // keep the transfer's steering for the delayed read data
  // so a later ndn change leaves it alone
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_off <= '0;
      rsp_siz <= '0;
      rsp_ndn <= 1'b0;
    end else if (trn) begin
      rsp_off <= req_off;
      rsp_siz <= siz;
      rsp_ndn <= ndn;
    end
  end

  assign rsp_top = `TCB_OFF_W'((1 << rsp_siz) - 1);

  // undo the lane mapping, bytes land at the low end
  always_comb begin
    for (int i = 0; i < `TCB_BYT_N; i++) begin
      if (`TCB_OFF_W'(i) > rsp_top) begin
        // beyond the access size
        rdt.byt[i] = '0;
      end else if (rsp_ndn) begin
        rdt.byt[i] = mem_rdt.byt[rsp_top - `TCB_OFF_W'(i) + rsp_off];
      end else begin
        rdt.byt[i] = mem_rdt.byt[`TCB_OFF_W'(i) + rsp_off];
      end
    end
  end

  // status unchanged
  assign sts = mem_sts;

endmodule

// ==== tcb_mem.sv ====
// byte enable word memory for the TCB subsystem
// one cycle read latency, address limit status, write recovery stall

`timescale 1ns/1ps

`include "tcb_settings.svh"

module tcb_mem (
  input  logic                   clk,
  input  logic                   rst_n,
  // byte enable request
  input  logic                   mem_vld,
  input  logic                   mem_wen,
  input  logic [`TCB_WAD_W-1:0]  mem_adr,
  input  logic [`TCB_BYT_N-1:0]  mem_ben,
  input  tcb_pkg::tcb_data_t     mem_wdt,
  // word address limit from the config block
  input  logic [`TCB_LIM_W-1:0]  lim,
  // response
  output tcb_pkg::tcb_data_t     mem_rdt,
  output logic                   mem_sts,
  output logic                   mem_rdy
);

  // storage
  logic [`TCB_DAT_W-1:0] mem_arr [0:`TCB_MEM_D-1];

  // transfer and out of range flag
  logic trn;
  logic err;

  assign trn = mem_vld & mem_rdy;
  // at or above the limit is an error
  assign err = ({1'b0, mem_adr} >= lim);

  //////////////////////////////////////////////////
  // write and read
  //////////////////////////////////////////////////

  // only enabled lanes change, nothing past the limit
  always_ff @(posedge clk) begin
    if (trn && mem_wen && !err) begin
      for (int i = 0; i < `TCB_BYT_N; i++) begin
        if (mem_ben[i]) begin
          mem_arr[mem_adr][8*i +: 8] <= mem_wdt.wrd[8*i +: 8];
        end
      end
    end
  end

  // read data one cycle after the transfer, zero on error
  always_ff @(posedge clk) begin
    if (trn) begin
      mem_rdt.wrd <= err ? '0 : mem_arr[mem_adr];
    end
  end

  //////////////////////////////////////////////////
  // status and handshake
  //////////////////////////////////////////////////

  // one idle cycle after every accepted write
  // status holds until the next transfer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_rdy <= 1'b1;
      mem_sts <= 1'b0;
    end else begin
      mem_rdy <= ~(trn & mem_wen);
      if (trn) begin
        mem_sts <= err;
      end
    end
  end

endmodule

// ==== tcb_sys_top.sv ====
// TCB subsystem top level
// config registers, size converter and word memory

`timescale 1ns/1ps

`include "tcb_settings.svh"

module tcb_sys_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // manager port, log size mode
  input  logic                   vld,
  input  logic                   wen,
  input  logic [`TCB_ADR_W-1:0]  adr,
  input  logic [`TCB_SIZ_W-1:0]  siz,
  input  tcb_pkg::tcb_data_t     wdt,
  output logic                   rdy,
  output tcb_pkg::tcb_data_t     rdt,
  output logic                   sts,
  // configuration port
  input  logic                   cfg_wen,
  input  logic                   cfg_adr,
  input  tcb_pkg::tcb_data_t     cfg_wdt,
  output tcb_pkg::tcb_data_t     cfg_rdt
);

  import tcb_pkg::*;

  // converter to memory
  logic                  mem_vld;
  logic                  mem_wen;
  logic [`TCB_WAD_W-1:0] mem_adr;
  logic [`TCB_BYT_N-1:0] mem_ben;
  tcb_data_t             mem_wdt;
  tcb_data_t             mem_rdt;
  logic                  mem_sts;
  logic                  mem_rdy;
  // config controls
  logic                  ndn;
  logic [`TCB_LIM_W-1:0] lim;

  tcb_cfg_regs u_cfg (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg_wen (cfg_wen),
    .cfg_adr (cfg_adr),
    .cfg_wdt (cfg_wdt),
    .cfg_rdt (cfg_rdt),
    .ndn     (ndn),
    .lim     (lim)
  );

  tcb_logsize2byteena u_conv (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .wdt     (wdt),
    .ndn     (ndn),
    .rdy     (rdy),
    .rdt     (rdt),
    .sts     (sts),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt),
    .mem_sts (mem_sts),
    .mem_rdy (mem_rdy)
  );

  tcb_mem u_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .lim     (lim),
    .mem_rdt (mem_rdt),
    .mem_sts (mem_sts),
    .mem_rdy (mem_rdy)
  );

endmodule

// ==== tcb_sys_chk.sv ====
// concurrent checks on the converter and its memory side
// byte enable count, rdy recovery, status before the first transfer

`timescale 1ns/1ps

`include "tcb_settings.svh"

module tcb_sys_chk (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   vld,
  input  logic                   rdy,
  input  logic [`TCB_SIZ_W-1:0]  siz,
  input  logic [`TCB_BYT_N-1:0]  ben,
  input  logic                   sts
);

  // set by the first transfer after reset
  logic seen_trn;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seen_trn <= 1'b0;
    end else if (vld && rdy) begin
      seen_trn <= 1'b1;
    end
  end

  // 2**siz lanes on every transfer
  ben_count: assert property (@(posedge clk) disable iff (!rst_n)
    (vld && rdy) |-> ($countones(ben) == (32'd1 << siz)))
    else $error("byte enable count does not match size code %0d", siz);

  // write recovery is a single cycle
  rdy_gap: assert property (@(posedge clk) disable iff (!rst_n)
    !rdy |=> rdy)
    else $error("rdy low for two cycles in a row");

  // nothing to report before a request
  sts_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_trn |-> !sts)
    else $error("status set before the first transfer");

endmodule

// memory side of the converter, request and response
bind tcb_logsize2byteena tcb_sys_chk u_chk (
  .clk   (clk),
  .rst_n (rst_n),
  .vld   (mem_vld),
  .rdy   (mem_rdy),
  .siz   (siz),
  .ben   (mem_ben),
  .sts   (mem_sts)
);

// ==== tcb_sys_tb.sv ====
// testbench for the TCB subsystem
// clock, reset, reference byte memory, stimulus table, compare tasks

`timescale 1ns/1ps

`include "tcb_settings.svh"

module tcb_sys_tb;

  import tcb_pkg::*;

  // table entry kinds
  localparam logic [1:0] KIND_BUS    = 2'd0;
  localparam logic [1:0] KIND_CFG_WR = 2'd1;
  localparam logic [1:0] KIND_CFG_RD = 2'd2;
  // register map shared with the config block
  localparam logic CFG_NDN = 1'b0;
  localparam logic CFG_LIM = 1'b1;
  // cycles allowed for rdy to come back
  localparam int RDY_TMO = 16;

  typedef struct packed {
    logic [1:0]            kind;
    logic                  wen;
    // byte address whose bit 0 doubles as register address
    logic [`TCB_ADR_W-1:0] adr;
    logic [`TCB_SIZ_W-1:0] siz;
    // write data or expected value when mdl is low
    logic [`TCB_DAT_W-1:0] dat;
    logic                  mdl;
    logic                  sts;
  } entry_t;

  logic                  clk;
  logic                  rst_n;
  logic                  vld;
  logic                  wen;
  logic [`TCB_ADR_W-1:0] adr;
  logic [`TCB_SIZ_W-1:0] siz;
  tcb_data_t             wdt;
  logic                  rdy;
  tcb_data_t             rdt;
  logic                  sts;
  logic                  cfg_wen;
  logic                  cfg_adr;
  tcb_data_t             cfg_wdt;
  tcb_data_t             cfg_rdt;

  entry_t tbl[$];
  string  names[$];
  // reference byte memory and config copies
  logic [7:0] ref_mem [0:`TCB_MEM_D*`TCB_BYT_N-1];
  logic       ref_ndn;
  int         ref_lim;

  tcb_sys_top u_tcb_sys_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .wdt     (wdt),
    .rdy     (rdy),
    .rdt     (rdt),
    .sts     (sts),
    .cfg_wen (cfg_wen),
    .cfg_adr (cfg_adr),
    .cfg_wdt (cfg_wdt),
    .cfg_rdt (cfg_rdt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // table builders
  //////////////////////////////////////////////////

  task automatic bus_wr(input string name, input logic [`TCB_ADR_W-1:0] a,
                        input logic [`TCB_SIZ_W-1:0] s, input logic [31:0] d, input logic st);
    tbl.push_back('{kind: KIND_BUS, wen: 1'b1, adr: a, siz: s, dat: d, mdl: 1'b0, sts: st});
    names.push_back(name);
  endtask

  task automatic bus_rd(input string name, input logic [`TCB_ADR_W-1:0] a,
                        input logic [`TCB_SIZ_W-1:0] s, input logic m, input logic [31:0] d,
                        input logic st);
    tbl.push_back('{kind: KIND_BUS, wen: 1'b0, adr: a, siz: s, dat: d, mdl: m, sts: st});
    names.push_back(name);
  endtask

  task automatic cfg_wr(input string name, input logic a, input logic [31:0] d);
    tbl.push_back('{kind: KIND_CFG_WR, wen: 1'b1, adr: {11'd0, a}, siz: 2'd0, dat: d,
                    mdl: 1'b0, sts: 1'b0});
    names.push_back(name);
  endtask

  task automatic cfg_rd(input string name, input logic a, input logic [31:0] d);
    tbl.push_back('{kind: KIND_CFG_RD, wen: 1'b0, adr: {11'd0, a}, siz: 2'd0, dat: d,
                    mdl: 1'b0, sts: 1'b0});
    names.push_back(name);
  endtask

  task automatic build_table;
    // reset values
    cfg_rd("cfg_rst_ndn", CFG_NDN, 32'd0);
    cfg_rd("cfg_rst_lim", CFG_LIM, 32'd`TCB_MEM_D);
    // aligned little-endian words
    bus_wr("le_w_000", 12'h000, 2'd2, 32'h1122_3344, 1'b0);
    bus_wr("le_w_004", 12'h004, 2'd2, $urandom(), 1'b0);
    bus_rd("le_r_000", 12'h000, 2'd2, 1'b1, 32'h0, 1'b0);
    bus_rd("le_r_004", 12'h004, 2'd2, 1'b1, 32'h0, 1'b0);
    // sub-word writes at every offset
    // the half at 3 wraps to lane 0
    bus_wr("sw_init", 12'h010, 2'd2, $urandom(), 1'b0);
    bus_wr("sw_b_off0", 12'h010, 2'd0, $urandom(), 1'b0);
    bus_wr("sw_b_off1", 12'h011, 2'd0, $urandom(), 1'b0);
    bus_wr("sw_h_off2", 12'h012, 2'd1, $urandom(), 1'b0);
    bus_wr("sw_h_off3", 12'h013, 2'd1, $urandom(), 1'b0);
    bus_rd("sw_r_word", 12'h010, 2'd2, 1'b1, 32'h0, 1'b0);
    bus_rd("sw_r_b_off1", 12'h011, 2'd0, 1'b1, 32'h0, 1'b0);
    bus_rd("sw_r_h_off3", 12'h013, 2'd1, 1'b1, 32'h0, 1'b0);
    bus_rd("sw_r_h_off1", 12'h011, 2'd1, 1'b1, 32'h0, 1'b0);
    // big-endian
    cfg_wr("be_on", CFG_NDN, 32'd1);
    cfg_rd("be_rdback", CFG_NDN, 32'd1);
    bus_wr("be_w_020", 12'h020, 2'd2, 32'h1122_3344, 1'b0);
    bus_wr("be_h_off2", 12'h022, 2'd1, $urandom(), 1'b0);
    bus_wr("be_h_off3", 12'h023, 2'd1, $urandom(), 1'b0);
    bus_rd("be_r_020", 12'h020, 2'd2, 1'b1, 32'h0, 1'b0);
    bus_rd("be_r_h_off1", 12'h021, 2'd1, 1'b1, 32'h0, 1'b0);
    bus_rd("be_r_h_000", 12'h000, 2'd1, 1'b1, 32'h0, 1'b0);
    cfg_wr("be_off", CFG_NDN, 32'd0);
    bus_rd("le_r_020", 12'h020, 2'd2, 1'b1, 32'h0, 1'b0);
    // address limit at word 8
    cfg_wr("lim_set", CFG_LIM, 32'd8);
    cfg_rd("lim_rdback", CFG_LIM, 32'd8);
    bus_rd("lim_r_below", 12'h010, 2'd2, 1'b1, 32'h0, 1'b0);
    bus_wr("lim_w_above", 12'h020, 2'd2, $urandom(), 1'b1);
    bus_rd("lim_r_above", 12'h024, 2'd2, 1'b0, 32'h0, 1'b1);
    cfg_wr("lim_clr", CFG_LIM, 32'd`TCB_MEM_D);
    bus_rd("lim_r_kept", 12'h020, 2'd2, 1'b1, 32'h0, 1'b0);
    // read right behind a write
    bus_wr("bp_w_030", 12'h030, 2'd2, $urandom(), 1'b0);
    bus_rd("bp_r_030", 12'h030, 2'd2, 1'b1, 32'h0, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // byte k of the request sits at lane (off + k) mod 4
  // big-endian reverses k
  task automatic model_write(input logic [`TCB_ADR_W-1:0] a, input logic [`TCB_SIZ_W-1:0] s,
                             input tcb_data_t d, input logic be);
    int n;
    int off;
    int base;
    int k;
    n = 1 << s;
    off = int'(a) % `TCB_BYT_N;
    base = int'(a) - off;
    for (k = 0; k < n; k++) begin
      ref_mem[`TCB_ADR_W'(base + (off + k) % `TCB_BYT_N)] = d.byt[2'(be ? n - 1 - k : k)];
    end
  endtask

  // bytes land at the low end of the word
  // unused bytes read as zero
  function automatic tcb_data_t model_read(input logic [`TCB_ADR_W-1:0] a,
                                           input logic [`TCB_SIZ_W-1:0] s, input logic be);
    tcb_data_t r;
    int n;
    int off;
    int base;
    int k;
    r.wrd = '0;
    n = 1 << s;
    off = int'(a) % `TCB_BYT_N;
    base = int'(a) - off;
    for (k = 0; k < n; k++) begin
      r.byt[2'(be ? n - 1 - k : k)] = ref_mem[`TCB_ADR_W'(base + (off + k) % `TCB_BYT_N)];
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_data(input string name, input tcb_data_t exp, input tcb_data_t act);
    if (act.wrd !== exp.wrd) begin
      $display("[ERROR] %s: rdt expected %h, actual %h", name, exp.wrd, act.wrd);
      $display("TB FAILED");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic check_sts(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: sts expected %b, actual %b", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "status mismatch");
    end
  endtask

  task automatic check_rdy(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: rdy expected %b, actual %b", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "handshake mismatch");
    end
  endtask

  task automatic check_cfg(input string name, input tcb_data_t exp, input tcb_data_t act);
    if (act.wrd !== exp.wrd) begin
      $display("[ERROR] %s: cfg_rdt expected %h, actual %h", name, exp.wrd, act.wrd);
      $display("TB FAILED");
      $fatal(1, "register readback mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // drivers entered 2 ns after an edge
  //////////////////////////////////////////////////

  task automatic run_bus(input string name, input entry_t e);
    tcb_data_t d;
    tcb_data_t exp_rdt;
    int        cnt;
    d.wrd = e.dat;
    vld = 1'b1;
    wen = e.wen;
    adr = e.adr;
    siz = e.siz;
    wdt = d;
    cnt = 0;
    // request held while rdy is low
    while (!rdy) begin
      if (cnt == RDY_TMO) begin
        $display("timeout: rdy stayed low for %0d cycles in %s", RDY_TMO, name);
        $display("TB FAILED");
        $fatal(1, "rdy timeout");
      end
      @(posedge clk);
      #2;
      cnt++;
    end
    // transfer edge then the response cycle
    @(posedge clk);
    #2;
    vld = 1'b0;
    wen = 1'b0;
    if (e.wen) begin
      // writes past the limit leave the memory alone
      if (int'(e.adr) / `TCB_BYT_N < ref_lim) begin
        model_write(e.adr, e.siz, d, ref_ndn);
      end
    end else begin
      exp_rdt = e.mdl ? model_read(e.adr, e.siz, ref_ndn) : d;
      check_data(name, exp_rdt, rdt);
    end
    check_sts(name, e.sts, sts);
    // a write costs one recovery cycle
    check_rdy(name, !e.wen, rdy);
  endtask

  task automatic write_cfg(input entry_t e);
    cfg_wen = 1'b1;
    cfg_adr = e.adr[0];
    cfg_wdt.wrd = e.dat;
    @(posedge clk);
    #2;
    cfg_wen = 1'b0;
    if (e.adr[0] == CFG_LIM) begin
      ref_lim = int'(e.dat[`TCB_LIM_W-1:0]);
    end else begin
      ref_ndn = e.dat[0];
    end
  endtask

  task automatic read_cfg(input string name, input entry_t e);
    tcb_data_t exp_cfg;
    exp_cfg.wrd = e.dat;
    cfg_adr = e.adr[0];
    @(posedge clk);
    #2;
    check_cfg(name, exp_cfg, cfg_rdt);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    vld = 1'b0;
    wen = 1'b0;
    adr = '0;
    siz = '0;
    wdt = '0;
    cfg_wen = 1'b0;
    cfg_adr = 1'b0;
    cfg_wdt = '0;
    ref_ndn = 1'b0;
    ref_lim = `TCB_MEM_D;
    void'($urandom(32'h8b5e_2908));
    build_table();
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < tbl.size(); i++) begin
      case (tbl[i].kind)
        KIND_BUS:    run_bus(names[i], tbl[i]);
        KIND_CFG_WR: write_cfg(tbl[i]);
        default:     read_cfg(names[i], tbl[i]);
      endcase
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
tcb_pkg.sv
tcb_cfg_regs.sv
tcb_logsize2byteena.sv
tcb_mem.sv
tcb_sys_top.sv
tcb_sys_chk.sv
tcb_sys_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the TCB subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
  --top-module tcb_sys_tb -o tcb_sys_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/tcb_sys_sim)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
